//--- tests/vcu_stim.txt
// instr vtype illegal fu_type aluop is_signed rs1_type eew single_bit vd_widen vd
// all hex, enum codes in vec_ctrl_pkg declaration order
022180d7 10 0 0 0 1 0 2 0 0 01
0221c157 08 0 0 0 1 1 1 0 0 02
0221b1d7 00 0 0 0 1 2 0 0 0 03
0a218257 10 0 0 1 1 0 2 0 0 04
16218357 10 0 0 6 1 0 2 0 0 06
262184d7 10 0 0 2 0 0 2 0 0 09
2621b557 08 0 0 2 0 2 1 0 0 0a
6e2185d7 10 0 0 5 1 0 2 1 0 0b
6e21c657 08 0 0 5 1 1 1 1 0 0c
962186d7 10 0 0 7 0 0 2 0 0 0d
9621b757 00 0 0 7 0 2 0 0 0 0e
0221a857 10 0 1 0 1 0 2 0 0 10
0621a8d7 08 0 1 2 0 0 1 0 0 11
9621a957 10 0 2 0 1 0 2 0 0 12
9e21e9d7 08 0 2 0 1 1 1 0 0 13
8621aa57 10 0 3 0 1 0 2 0 0 14
8e21ead7 00 0 3 0 1 1 0 0 0 15
6621ab57 00 0 4 2 0 0 2 0 0 16
6a21abd7 08 0 4 3 0 0 2 0 0 17
6e21ac57 00 0 4 4 0 0 2 0 0 18
c621acd7 00 0 0 0 1 0 1 0 1 19
ca21ed57 08 0 0 1 0 1 2 0 1 1a
c621edd7 10 0 0 0 1 1 2 0 1 1b
0201de07 00 0 5 0 0 1 2 0 0 1c
0a218e87 10 0 5 0 0 1 0 0 0 1d
0201ef27 00 0 6 0 0 1 2 0 0 1e
0a21dfa7 10 0 6 0 0 1 1 0 0 1f
0221f0d7 10 1 0 0 0 0 2 0 0 01
0a21b157 08 1 0 0 0 0 1 0 0 02
06218187 00 1 0 0 0 0 0 0 0 03
0201f207 10 1 0 0 0 0 2 0 0 04
00a50533 08 1 0 0 0 0 1 0 0 0a

//--- filelist.f
+incdir+source
source/vec_isa_pkg.sv
source/vec_ctrl_pkg.sv
source/vec_insn_decoder.sv
source/decode_queue.sv
source/vec_ctrl_gen.sv
source/vector_control_unit.sv
tests/vcu_properties.sv
tests/tb_vector_control_unit.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_vector_control_unit -Mdir obj_dir -o sim_vcu

out=$(./obj_dir/sim_vcu 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation passed"; then
  exit 0
fi
exit 1

//--- tests/tb_vector_control_unit.sv
`timescale 1ns/1ps

module tb_vector_control_unit;

  localparam int          NUM_CASES  = 32;
  localparam int          NUM_COLS   = 11;
  localparam int          MEM_WORDS  = NUM_CASES * NUM_COLS;
  localparam int          WAIT_LIMIT = 200;
  localparam logic [31:0] RNG_SEED   = 32'h7fe5f85b;

  // column order of the stimulus file
  localparam int COL_INSTR   = 0;
  localparam int COL_VTYPE   = 1;
  localparam int COL_ILLEGAL = 2;
  localparam int COL_FU      = 3;
  localparam int COL_ALUOP   = 4;
  localparam int COL_SIGNED  = 5;
  localparam int COL_RS1     = 6;
  localparam int COL_EEW     = 7;
  localparam int COL_BIT     = 8;
  localparam int COL_WIDEN   = 9;
  localparam int COL_VD      = 10;

  logic                      CLK = 1'b0;
  logic                      arst_n;
  logic                      in_valid;
  logic                      in_ready;
  vec_isa_pkg::instr_t       instr;
  logic [7:0]                vtype;
  logic                      out_valid;
  logic                      out_ready = 1'b0;
  vec_ctrl_pkg::vop_t        op;
  logic                      illegal;
  vec_ctrl_pkg::fu_type_t    fu_type;
  vec_ctrl_pkg::valu_op_t    aluop;
  vec_ctrl_pkg::signedness_t is_signed;
  vec_ctrl_pkg::rs1_type_t   rs1_type;
  logic                      single_bit;
  logic                      vd_widen;
  vec_ctrl_pkg::sew_t        eew;
  vec_isa_pkg::vreg_idx_t    vd;
  vec_isa_pkg::vreg_idx_t    vs1;
  vec_isa_pkg::vreg_idx_t    vs2;

  logic [31:0] stim_mem [MEM_WORDS];
  logic [31:0] gap_state;
  logic [31:0] rdy_state  = ~RNG_SEED;
  int          stall_left = 0;
  int          seen       = 0;

  always #4 CLK = ~CLK;

  vector_control_unit u_vector_control_unit (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .instr      (instr),
    .vtype      (vtype),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .op         (op),
    .illegal    (illegal),
    .fu_type    (fu_type),
    .aluop      (aluop),
    .is_signed  (is_signed),
    .rs1_type   (rs1_type),
    .single_bit (single_bit),
    .vd_widen   (vd_widen),
    .eew        (eew),
    .vd         (vd),
    .vs1        (vs1),
    .vs2        (vs2)
  );

  bind vector_control_unit vcu_properties u_props (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .op         (op),
    .illegal    (illegal),
    .fu_type    (fu_type),
    .aluop      (aluop),
    .is_signed  (is_signed),
    .rs1_type   (rs1_type),
    .single_bit (single_bit),
    .vd_widen   (vd_widen),
    .eew        (eew),
    .vd         (vd),
    .vs1        (vs1),
    .vs2        (vs2)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] expected(input int rec, input int col);
    return stim_mem[rec * NUM_COLS + col];
  endfunction

  // op from the instruction encoding, OPM forms have funct3[1:0] == 2'b10
  function automatic vec_ctrl_pkg::vop_t expected_op(input int rec);
    logic [31:0]        w;
    logic               opm;
    vec_ctrl_pkg::vop_t res;
    w   = expected(rec, COL_INSTR);
    opm = (w[13:12] == 2'b10);
    res = vec_ctrl_pkg::BAD_OP;
    if (expected(rec, COL_ILLEGAL) != 32'd0) begin
      res = vec_ctrl_pkg::BAD_OP;
    end else if (w[6:0] == 7'b0000111) begin
      res = w[27] ? vec_ctrl_pkg::OP_VLSE : vec_ctrl_pkg::OP_VLE;
    end else if (w[6:0] == 7'b0100111) begin
      res = w[27] ? vec_ctrl_pkg::OP_VSSE : vec_ctrl_pkg::OP_VSE;
    end else begin
      case ({opm, w[31:26]})
        7'b0_000000: res = vec_ctrl_pkg::OP_VADD;
        7'b0_000010: res = vec_ctrl_pkg::OP_VSUB;
        7'b0_000011: res = vec_ctrl_pkg::OP_VRSUB;
        7'b0_000100: res = vec_ctrl_pkg::OP_VMINU;
        7'b0_000101: res = vec_ctrl_pkg::OP_VMIN;
        7'b0_000110: res = vec_ctrl_pkg::OP_VMAXU;
        7'b0_000111: res = vec_ctrl_pkg::OP_VMAX;
        7'b0_001001: res = vec_ctrl_pkg::OP_VAND;
        7'b0_001010: res = vec_ctrl_pkg::OP_VOR;
        7'b0_001011: res = vec_ctrl_pkg::OP_VXOR;
        7'b0_011000: res = vec_ctrl_pkg::OP_VMSEQ;
        7'b0_011001: res = vec_ctrl_pkg::OP_VMSNE;
        7'b0_011010: res = vec_ctrl_pkg::OP_VMSLTU;
        7'b0_011011: res = vec_ctrl_pkg::OP_VMSLT;
        7'b0_100101: res = vec_ctrl_pkg::OP_VSLL;
        7'b0_101000: res = vec_ctrl_pkg::OP_VSRL;
        7'b0_101001: res = vec_ctrl_pkg::OP_VSRA;
        7'b1_000000: res = vec_ctrl_pkg::OP_VREDSUM;
        7'b1_000001: res = vec_ctrl_pkg::OP_VREDAND;
        7'b1_000010: res = vec_ctrl_pkg::OP_VREDOR;
        7'b1_000011: res = vec_ctrl_pkg::OP_VREDXOR;
        7'b1_011001: res = vec_ctrl_pkg::OP_VMAND;
        7'b1_011010: res = vec_ctrl_pkg::OP_VMOR;
        7'b1_011011: res = vec_ctrl_pkg::OP_VMXOR;
        7'b1_100000: res = vec_ctrl_pkg::OP_VDIVU;
        7'b1_100001: res = vec_ctrl_pkg::OP_VDIV;
        7'b1_100010: res = vec_ctrl_pkg::OP_VREMU;
        7'b1_100011: res = vec_ctrl_pkg::OP_VREM;
        7'b1_100100: res = vec_ctrl_pkg::OP_VMULHU;
        7'b1_100101: res = vec_ctrl_pkg::OP_VMUL;
        7'b1_100111: res = vec_ctrl_pkg::OP_VMULH;
        7'b1_110000: res = vec_ctrl_pkg::OP_VWADDU;
        7'b1_110001: res = vec_ctrl_pkg::OP_VWADD;
        7'b1_110010: res = vec_ctrl_pkg::OP_VWSUBU;
        7'b1_110011: res = vec_ctrl_pkg::OP_VWSUB;
        default:     res = vec_ctrl_pkg::BAD_OP;
      endcase
    end
    return res;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_field(input int rec, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] case %0d %s: expected %0h, actual %0h", rec, field, exp, act);
      abort_run("output does not match the stimulus record");
    end
  endtask

  task automatic check_record(input int rec);
    logic [31:0] word;
    word = expected(rec, COL_INSTR);
    check_field(rec, "op", 32'(expected_op(rec)), 32'(op));
    check_field(rec, "illegal", expected(rec, COL_ILLEGAL), 32'(illegal));
    check_field(rec, "fu_type", expected(rec, COL_FU), 32'(fu_type));
    check_field(rec, "aluop", expected(rec, COL_ALUOP), 32'(aluop));
    check_field(rec, "is_signed", expected(rec, COL_SIGNED), 32'(is_signed));
    check_field(rec, "rs1_type", expected(rec, COL_RS1), 32'(rs1_type));
    check_field(rec, "eew", expected(rec, COL_EEW), 32'(eew));
    check_field(rec, "single_bit", expected(rec, COL_BIT), 32'(single_bit));
    check_field(rec, "vd_widen", expected(rec, COL_WIDEN), 32'(vd_widen));
    check_field(rec, "vd", expected(rec, COL_VD), 32'(vd));
    // register fields pass straight through from the instruction word
    check_field(rec, "vs1", 32'(word[19:15]), 32'(vs1));
    check_field(rec, "vs2", 32'(word[24:20]), 32'(vs2));
  endtask

  // random back-pressure, with an occasional long stall to fill the queue
  always @(posedge CLK) begin
    rdy_state = xorshift32(rdy_state);
    if (!arst_n) begin
      out_ready <= 1'b0;
    end else if (stall_left != 0) begin
      out_ready  <= 1'b0;
      stall_left = stall_left - 1;
    end else if (rdy_state[3:0] == 4'h0) begin
      out_ready  <= 1'b0;
      stall_left = 9;
    end else begin
      out_ready <= (rdy_state[5:4] != 2'b00);
    end
  end

  // sampled mid-cycle, the transfer itself happens on the next rising edge
  always @(negedge CLK) begin
    if (arst_n && out_valid && out_ready) begin
      if (seen >= NUM_CASES) begin
        abort_run("an output appeared with no stimulus record left");
      end else begin
        check_record(seen);
        seen = seen + 1;
      end
    end
  end

  initial begin
    int idle;
    int cycles;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    instr    = '0;
    vtype    = '0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      stim_mem[a] = 32'ha5a50000 | 32'(a);
    end
    $readmemh("tests/vcu_stim.txt", stim_mem);
    // a record still holding the fill pattern means the file was short
    for (int r = 0; r < NUM_CASES; r++) begin
      if (expected(r, COL_VD) > 32'd31) begin
        abort_run("the stimulus file holds fewer records than expected");
      end
    end
    gap_state = RNG_SEED;

    repeat (5) @(posedge CLK);
    arst_n <= 1'b1;

    for (int i = 0; i < NUM_CASES; i++) begin
      gap_state = xorshift32(gap_state);
      idle = int'(gap_state[1:0]);
      if (idle != 0) begin
        in_valid <= 1'b0;
        repeat (idle) @(posedge CLK);
      end
      in_valid <= 1'b1;
      instr    <= expected(i, COL_INSTR);
      vtype    <= 8'(expected(i, COL_VTYPE));
      cycles = 0;
      do begin
        @(negedge CLK);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
          abort_run("an instruction was never accepted by the DUT");
        end
      end while (!in_ready);
      @(posedge CLK);
    end
    in_valid <= 1'b0;

    cycles = 0;
    while (seen < NUM_CASES) begin
      @(posedge CLK);
      cycles++;
      if (cycles > 10 * WAIT_LIMIT) begin
        abort_run("the DUT stopped producing outputs before the last record");
      end
    end
    // give a stray extra output the chance to show up
    repeat (10) @(posedge CLK);

    if (seen == NUM_CASES) begin
      $display("Simulation passed");
      $finish;
    end else begin
      abort_run("the number of outputs differs from the number of records");
    end
  end

endmodule

//--- tests/vcu_properties.sv
`timescale 1ns/1ps

module vcu_properties (
  input logic                      CLK,
  input logic                      arst_n,
  input logic                      in_ready,
  input logic                      out_valid,
  input logic                      out_ready,
  input vec_ctrl_pkg::vop_t        op,
  input logic                      illegal,
  input vec_ctrl_pkg::fu_type_t    fu_type,
  input vec_ctrl_pkg::valu_op_t    aluop,
  input vec_ctrl_pkg::signedness_t is_signed,
  input vec_ctrl_pkg::rs1_type_t   rs1_type,
  input logic                      single_bit,
  input logic                      vd_widen,
  input vec_ctrl_pkg::sew_t        eew,
  input vec_isa_pkg::vreg_idx_t    vd,
  input vec_isa_pkg::vreg_idx_t    vs1,
  input vec_isa_pkg::vreg_idx_t    vs2
);

  logic [34:0] ctrl_bundle;
  // out_ready over the last 6 edges, all ones when no stall was seen
  logic [5:0]  ready_hist;

  assign ctrl_bundle = {op, illegal, fu_type, aluop, is_signed, rs1_type,
                        single_bit, vd_widen, eew, vd, vs1, vs2};

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ready_hist <= '1;
    end else begin
      ready_hist <= {ready_hist[4:0], out_ready};
    end
  end

  a_out_idle_after_reset: assert property (@(posedge CLK) $rose(arst_n) |-> !out_valid)
    else $error("out_valid high right after reset");

  a_out_hold: assert property (@(posedge CLK) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(ctrl_bundle))
    else $error("output changed while stalled");

  // in_ready only drops once every stage behind the decoder is full
  a_in_ready_stall: assert property (@(posedge CLK) disable iff (!arst_n)
    !in_ready |-> out_valid && (!out_ready || !(&ready_hist)))
    else $error("in_ready low without a recent output stall");

endmodule

//--- source/vector_control_unit.sv
`timescale 1ns/1ps

module vector_control_unit (
  input  logic                      CLK,
  input  logic                      arst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  vec_isa_pkg::instr_t       instr,
  input  logic [7:0]                vtype,
  output logic                      out_valid,
  input  logic                      out_ready,
  output vec_ctrl_pkg::vop_t        op,
  output logic                      illegal,
  output vec_ctrl_pkg::fu_type_t    fu_type,
  output vec_ctrl_pkg::valu_op_t    aluop,
  output vec_ctrl_pkg::signedness_t is_signed,
  output vec_ctrl_pkg::rs1_type_t   rs1_type,
  output logic                      single_bit,
  output logic                      vd_widen,
  output vec_ctrl_pkg::sew_t        eew,
  output vec_isa_pkg::vreg_idx_t    vd,
  output vec_isa_pkg::vreg_idx_t    vs1,
  output vec_isa_pkg::vreg_idx_t    vs2
);

  logic                    dec_valid;
  logic                    dec_ready;
  vec_ctrl_pkg::dec_word_t dec_word;
  logic                    q_valid;
  logic                    q_ready;
  vec_ctrl_pkg::dec_word_t q_word;

  vec_insn_decoder u_decoder (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .instr     (instr),
    .vtype     (vtype),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_word  (dec_word)
  );

  // absorbs stalls from the execution side
  decode_queue u_queue (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .wr_valid (dec_valid),
    .wr_ready (dec_ready),
    .wr_data  (dec_word),
    .rd_valid (q_valid),
    .rd_ready (q_ready),
    .rd_data  (q_word)
  );

  vec_ctrl_gen u_ctrl (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .q_valid    (q_valid),
    .q_ready    (q_ready),
    .q_word     (q_word),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .op         (op),
    .illegal    (illegal),
    .fu_type    (fu_type),
    .aluop      (aluop),
    .is_signed  (is_signed),
    .rs1_type   (rs1_type),
    .single_bit (single_bit),
    .vd_widen   (vd_widen),
    .eew        (eew),
    .vd         (vd),
    .vs1        (vs1),
    .vs2        (vs2)
  );

endmodule

//--- source/vec_ctrl_gen.sv
`timescale 1ns/1ps

module vec_ctrl_gen (
  input  logic                      CLK,
  input  logic                      arst_n,
  input  logic                      q_valid,
  output logic                      q_ready,
  input  vec_ctrl_pkg::dec_word_t   q_word,
  output logic                      out_valid,
  input  logic                      out_ready,
  output vec_ctrl_pkg::vop_t        op,
  output logic                      illegal,
  output vec_ctrl_pkg::fu_type_t    fu_type,
  output vec_ctrl_pkg::valu_op_t    aluop,
  output vec_ctrl_pkg::signedness_t is_signed,
  output vec_ctrl_pkg::rs1_type_t   rs1_type,
  output logic                      single_bit,
  output logic                      vd_widen,
  output vec_ctrl_pkg::sew_t        eew,
  output vec_isa_pkg::vreg_idx_t    vd,
  output vec_isa_pkg::vreg_idx_t    vs1,
  output vec_isa_pkg::vreg_idx_t    vs2
);

  vec_ctrl_pkg::vop_t        q_op;
  vec_ctrl_pkg::rs1_type_t   q_form;
  vec_isa_pkg::vreg_idx_t    q_vd, q_vs1, q_vs2;
  vec_ctrl_pkg::sew_t        q_sew, q_mem_sew;
  vec_ctrl_pkg::fu_type_t    fu_next;
  vec_ctrl_pkg::valu_op_t    alu_next;
  vec_ctrl_pkg::signedness_t sgn_next;
  vec_ctrl_pkg::sew_t        eew_next;
  logic                      bit_next;
  logic                      widen_next;

  // word layout from msb: op, rs1 form, vd, vs1, vs2, sew, mem sew, vm, imm
  assign q_op      = vec_ctrl_pkg::vop_t'(q_word[32:27]);
  assign q_form    = vec_ctrl_pkg::rs1_type_t'(q_word[26:25]);
  assign q_vd      = q_word[24:20];
  assign q_vs1     = q_word[19:15];
  assign q_vs2     = q_word[14:10];
  assign q_sew     = vec_ctrl_pkg::sew_t'(q_word[9:8]);
  assign q_mem_sew = vec_ctrl_pkg::sew_t'(q_word[7:6]);

  always_comb begin
    case (q_op)
      vec_ctrl_pkg::OP_VREDSUM, vec_ctrl_pkg::OP_VREDAND,
      vec_ctrl_pkg::OP_VREDOR, vec_ctrl_pkg::OP_VREDXOR:   fu_next = vec_ctrl_pkg::RED;
      vec_ctrl_pkg::OP_VMUL, vec_ctrl_pkg::OP_VMULH,
      vec_ctrl_pkg::OP_VMULHU:                             fu_next = vec_ctrl_pkg::MUL;
      vec_ctrl_pkg::OP_VDIVU, vec_ctrl_pkg::OP_VDIV,
      vec_ctrl_pkg::OP_VREMU, vec_ctrl_pkg::OP_VREM:       fu_next = vec_ctrl_pkg::DIV;
      vec_ctrl_pkg::OP_VMAND, vec_ctrl_pkg::OP_VMOR,
      vec_ctrl_pkg::OP_VMXOR:                              fu_next = vec_ctrl_pkg::MASK;
      vec_ctrl_pkg::OP_VLE, vec_ctrl_pkg::OP_VLSE:         fu_next = vec_ctrl_pkg::LOAD_UNIT;
      vec_ctrl_pkg::OP_VSE, vec_ctrl_pkg::OP_VSSE:         fu_next = vec_ctrl_pkg::STORE_UNIT;
      default:                                             fu_next = vec_ctrl_pkg::ARITH;
    endcase
  end

  // mul, div and memory ops leave the ALU on add
  always_comb begin
    case (q_op)
      vec_ctrl_pkg::OP_VSUB, vec_ctrl_pkg::OP_VRSUB,
      vec_ctrl_pkg::OP_VWSUBU, vec_ctrl_pkg::OP_VWSUB:     alu_next = vec_ctrl_pkg::VALU_SUB;
      vec_ctrl_pkg::OP_VAND, vec_ctrl_pkg::OP_VREDAND,
      vec_ctrl_pkg::OP_VMAND:                              alu_next = vec_ctrl_pkg::VALU_AND;
      vec_ctrl_pkg::OP_VOR, vec_ctrl_pkg::OP_VREDOR,
      vec_ctrl_pkg::OP_VMOR:                               alu_next = vec_ctrl_pkg::VALU_OR;
      vec_ctrl_pkg::OP_VXOR, vec_ctrl_pkg::OP_VREDXOR,
      vec_ctrl_pkg::OP_VMXOR:                              alu_next = vec_ctrl_pkg::VALU_XOR;
      vec_ctrl_pkg::OP_VMSEQ, vec_ctrl_pkg::OP_VMSNE,
      vec_ctrl_pkg::OP_VMSLTU, vec_ctrl_pkg::OP_VMSLT:     alu_next = vec_ctrl_pkg::VALU_COMP;
      vec_ctrl_pkg::OP_VMINU, vec_ctrl_pkg::OP_VMIN,
      vec_ctrl_pkg::OP_VMAXU, vec_ctrl_pkg::OP_VMAX:       alu_next = vec_ctrl_pkg::VALU_MM;
      vec_ctrl_pkg::OP_VSLL, vec_ctrl_pkg::OP_VSRL,
      vec_ctrl_pkg::OP_VSRA:                               alu_next = vec_ctrl_pkg::VALU_SHIFT;
      default:                                             alu_next = vec_ctrl_pkg::VALU_ADD;
    endcase
  end

  always_comb begin
    case (q_op)
      vec_ctrl_pkg::OP_VADD, vec_ctrl_pkg::OP_VSUB, vec_ctrl_pkg::OP_VRSUB,
      vec_ctrl_pkg::OP_VMIN, vec_ctrl_pkg::OP_VMAX, vec_ctrl_pkg::OP_VMSEQ,
      vec_ctrl_pkg::OP_VMSNE, vec_ctrl_pkg::OP_VMSLT, vec_ctrl_pkg::OP_VREDSUM,
      vec_ctrl_pkg::OP_VMUL, vec_ctrl_pkg::OP_VMULH, vec_ctrl_pkg::OP_VDIV,
      vec_ctrl_pkg::OP_VREM, vec_ctrl_pkg::OP_VWADD,
      vec_ctrl_pkg::OP_VWSUB:  sgn_next = vec_ctrl_pkg::SIGNED;
      default:                 sgn_next = vec_ctrl_pkg::UNSIGNED;
    endcase
  end

  // compares write one mask bit per element
  assign bit_next = (q_op == vec_ctrl_pkg::OP_VMSEQ) || (q_op == vec_ctrl_pkg::OP_VMSNE) ||
                    (q_op == vec_ctrl_pkg::OP_VMSLTU) || (q_op == vec_ctrl_pkg::OP_VMSLT);

  assign widen_next = (q_op == vec_ctrl_pkg::OP_VWADDU) || (q_op == vec_ctrl_pkg::OP_VWADD) ||
                      (q_op == vec_ctrl_pkg::OP_VWSUBU) || (q_op == vec_ctrl_pkg::OP_VWSUB);

  always_comb begin
    eew_next = q_sew;
    if (widen_next) begin
      eew_next = (q_sew == vec_ctrl_pkg::SEW8) ? vec_ctrl_pkg::SEW16 : vec_ctrl_pkg::SEW32;
    end else if (fu_next == vec_ctrl_pkg::MASK) begin
      eew_next = vec_ctrl_pkg::SEW32;
    end else if ((q_op == vec_ctrl_pkg::OP_VLSE) || (q_op == vec_ctrl_pkg::OP_VSSE)) begin
      eew_next = q_mem_sew;
    end else if ((q_op == vec_ctrl_pkg::OP_VLE) || (q_op == vec_ctrl_pkg::OP_VSE)) begin
      eew_next = vec_ctrl_pkg::SEW32;
    end
  end

  assign q_ready = !out_valid || out_ready;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (q_valid && q_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (q_valid && q_ready) begin
      op         <= q_op;
      illegal    <= (q_op == vec_ctrl_pkg::BAD_OP);
      fu_type    <= fu_next;
      aluop      <= alu_next;
      is_signed  <= sgn_next;
      rs1_type   <= q_form;
      single_bit <= bit_next;
      vd_widen   <= widen_next;
      eew        <= eew_next;
      vd         <= q_vd;
      vs1        <= q_vs1;
      vs2        <= q_vs2;
    end
  end

endmodule

//--- source/decode_queue.sv
`timescale 1ns/1ps
`include "vcu_macros.svh"

module decode_queue #(
  // power of two, at least 2, so the pointers wrap on their own
  parameter int DEPTH = `VCU_QUEUE_DEPTH
) (
  input  logic                    CLK,
  input  logic                    arst_n,
  input  logic                    wr_valid,
  output logic                    wr_ready,
  input  vec_ctrl_pkg::dec_word_t wr_data,
  output logic                    rd_valid,
  input  logic                    rd_ready,
  output vec_ctrl_pkg::dec_word_t rd_data
);

  localparam int PTR_W = $clog2(DEPTH);

  vec_ctrl_pkg::dec_word_t mem [DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [PTR_W:0]          count;
  logic                    do_wr;
  logic                    do_rd;

  assign wr_ready = (count != (PTR_W+1)'(DEPTH));
  assign rd_valid = (count != '0);
  assign do_wr    = wr_valid && wr_ready;
  assign do_rd    = rd_valid && rd_ready;

  // head entry, no bypass from the write side
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

//--- source/vec_insn_decoder.sv
`timescale 1ns/1ps

module vec_insn_decoder (
  input  logic                    CLK,
  input  logic                    arst_n,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  vec_isa_pkg::instr_t     instr,
  input  logic [7:0]              vtype,
  output logic                    dec_valid,
  input  logic                    dec_ready,
  output vec_ctrl_pkg::dec_word_t dec_word
);

  vec_isa_pkg::opcode_t    opcode;
  vec_isa_pkg::vfunct3_t   funct3;
  vec_isa_pkg::vopi_t      funct6_opi;
  vec_isa_pkg::vopm_t      funct6_opm;
  vec_isa_pkg::vreg_idx_t  vd;
  vec_isa_pkg::vreg_idx_t  vs1;
  vec_isa_pkg::vreg_idx_t  vs2;
  logic [4:0]              imm5;
  logic                    vm;
  logic                    mew;
  logic [2:0]              nf;
  vec_isa_pkg::mop_t       mop;
  vec_isa_pkg::width_t     width;
  logic                    f_ivv, f_ivx, f_ivi, f_mvv, f_mvx;
  logic                    opi_vx, opi_xi, opi_all, opm_vx;
  logic                    is_load, is_store, mem_ok;
  vec_ctrl_pkg::vop_t      op;
  vec_ctrl_pkg::rs1_type_t rs1_form;
  vec_ctrl_pkg::sew_t      sew, mem_sew;

  // field extraction
  assign opcode     = vec_isa_pkg::opcode_t'(instr[6:0]);
  assign vd         = instr[11:7];
  assign funct3     = vec_isa_pkg::vfunct3_t'(instr[14:12]);
  assign width      = vec_isa_pkg::width_t'(instr[14:12]);
  assign vs1        = instr[19:15];
  assign imm5       = instr[19:15];
  assign vs2        = instr[24:20];
  assign vm         = instr[25];
  assign mop        = vec_isa_pkg::mop_t'(instr[27:26]);
  assign mew        = instr[28];
  assign nf         = instr[31:29];
  assign funct6_opi = vec_isa_pkg::vopi_t'(instr[31:26]);
  assign funct6_opm = vec_isa_pkg::vopm_t'(instr[31:26]);

  // vsew in vtype[5:3], legal widths keep bit 5 low
  assign sew = vec_ctrl_pkg::sew_t'(vtype[4:3]);

  assign f_ivv   = (opcode == vec_isa_pkg::VECTOR) && (funct3 == vec_isa_pkg::OPIVV);
  assign f_ivx   = (opcode == vec_isa_pkg::VECTOR) && (funct3 == vec_isa_pkg::OPIVX);
  assign f_ivi   = (opcode == vec_isa_pkg::VECTOR) && (funct3 == vec_isa_pkg::OPIVI);
  assign f_mvv   = (opcode == vec_isa_pkg::VECTOR) && (funct3 == vec_isa_pkg::OPMVV);
  assign f_mvx   = (opcode == vec_isa_pkg::VECTOR) && (funct3 == vec_isa_pkg::OPMVX);
  assign opi_vx  = f_ivv || f_ivx;
  assign opi_xi  = f_ivx || f_ivi;
  assign opi_all = opi_vx || f_ivi;
  assign opm_vx  = f_mvv || f_mvx;

  assign is_load  = (opcode == vec_isa_pkg::LOAD_FP);
  assign is_store = (opcode == vec_isa_pkg::STORE_FP);
  // no segments, no indexed modes, no widths above 32
  assign mem_ok = ((width == vec_isa_pkg::WIDTH8) || (width == vec_isa_pkg::WIDTH16) ||
                   (width == vec_isa_pkg::WIDTH32)) &&
                  ((mop == vec_isa_pkg::MOP_UNIT) || (mop == vec_isa_pkg::MOP_STRIDED)) &&
                  !mew && (nf == 3'b000);

  always_comb begin
    op = vec_ctrl_pkg::BAD_OP;
    if (opi_all) begin
      case (funct6_opi)
        vec_isa_pkg::VADD:   op = vec_ctrl_pkg::OP_VADD;
        vec_isa_pkg::VSUB:   if (opi_vx)  op = vec_ctrl_pkg::OP_VSUB;
        vec_isa_pkg::VRSUB:  if (opi_xi)  op = vec_ctrl_pkg::OP_VRSUB;
        vec_isa_pkg::VMINU:  if (opi_vx)  op = vec_ctrl_pkg::OP_VMINU;
        vec_isa_pkg::VMIN:   if (opi_vx)  op = vec_ctrl_pkg::OP_VMIN;
        vec_isa_pkg::VMAXU:  if (opi_vx)  op = vec_ctrl_pkg::OP_VMAXU;
        vec_isa_pkg::VMAX:   if (opi_vx)  op = vec_ctrl_pkg::OP_VMAX;
        vec_isa_pkg::VAND:   op = vec_ctrl_pkg::OP_VAND;
        vec_isa_pkg::VOR:    op = vec_ctrl_pkg::OP_VOR;
        vec_isa_pkg::VXOR:   op = vec_ctrl_pkg::OP_VXOR;
        vec_isa_pkg::VMSEQ:  op = vec_ctrl_pkg::OP_VMSEQ;
        vec_isa_pkg::VMSNE:  op = vec_ctrl_pkg::OP_VMSNE;
        vec_isa_pkg::VMSLTU: if (opi_vx)  op = vec_ctrl_pkg::OP_VMSLTU;
        vec_isa_pkg::VMSLT:  if (opi_vx)  op = vec_ctrl_pkg::OP_VMSLT;
        vec_isa_pkg::VSLL:   op = vec_ctrl_pkg::OP_VSLL;
        vec_isa_pkg::VSRL:   op = vec_ctrl_pkg::OP_VSRL;
        vec_isa_pkg::VSRA:   op = vec_ctrl_pkg::OP_VSRA;
        default:             op = vec_ctrl_pkg::BAD_OP;
      endcase
    end else if (opm_vx) begin
      // reductions and mask logicals only exist as .vv / .mm
      case (funct6_opm)
        vec_isa_pkg::VREDSUM: if (f_mvv)  op = vec_ctrl_pkg::OP_VREDSUM;
        vec_isa_pkg::VREDAND: if (f_mvv)  op = vec_ctrl_pkg::OP_VREDAND;
        vec_isa_pkg::VREDOR:  if (f_mvv)  op = vec_ctrl_pkg::OP_VREDOR;
        vec_isa_pkg::VREDXOR: if (f_mvv)  op = vec_ctrl_pkg::OP_VREDXOR;
        vec_isa_pkg::VMAND:   if (f_mvv)  op = vec_ctrl_pkg::OP_VMAND;
        vec_isa_pkg::VMOR:    if (f_mvv)  op = vec_ctrl_pkg::OP_VMOR;
        vec_isa_pkg::VMXOR:   if (f_mvv)  op = vec_ctrl_pkg::OP_VMXOR;
        vec_isa_pkg::VMUL:    op = vec_ctrl_pkg::OP_VMUL;
        vec_isa_pkg::VMULH:   op = vec_ctrl_pkg::OP_VMULH;
        vec_isa_pkg::VMULHU:  op = vec_ctrl_pkg::OP_VMULHU;
        vec_isa_pkg::VDIVU:   op = vec_ctrl_pkg::OP_VDIVU;
        vec_isa_pkg::VDIV:    op = vec_ctrl_pkg::OP_VDIV;
        vec_isa_pkg::VREMU:   op = vec_ctrl_pkg::OP_VREMU;
        vec_isa_pkg::VREM:    op = vec_ctrl_pkg::OP_VREM;
        vec_isa_pkg::VWADDU:  op = vec_ctrl_pkg::OP_VWADDU;
        vec_isa_pkg::VWADD:   op = vec_ctrl_pkg::OP_VWADD;
        vec_isa_pkg::VWSUBU:  op = vec_ctrl_pkg::OP_VWSUBU;
        vec_isa_pkg::VWSUB:   op = vec_ctrl_pkg::OP_VWSUB;
        default:              op = vec_ctrl_pkg::BAD_OP;
      endcase
    end else if (is_load && mem_ok) begin
      op = (mop == vec_isa_pkg::MOP_STRIDED) ? vec_ctrl_pkg::OP_VLSE : vec_ctrl_pkg::OP_VLE;
    end else if (is_store && mem_ok) begin
      op = (mop == vec_isa_pkg::MOP_STRIDED) ? vec_ctrl_pkg::OP_VSSE : vec_ctrl_pkg::OP_VSE;
    end
  end

  // loads and stores take the base address from x[rs1]
  assign rs1_form = (op == vec_ctrl_pkg::BAD_OP)            ? vec_ctrl_pkg::V :
                    (is_load || is_store || f_ivx || f_mvx) ? vec_ctrl_pkg::X :
                    f_ivi                                   ? vec_ctrl_pkg::I :
                                                              vec_ctrl_pkg::V;

  always_comb begin
    case (width)
      vec_isa_pkg::WIDTH8:  mem_sew = vec_ctrl_pkg::SEW8;
      vec_isa_pkg::WIDTH16: mem_sew = vec_ctrl_pkg::SEW16;
      default:              mem_sew = vec_ctrl_pkg::SEW32;
    endcase
  end

  assign in_ready = !dec_valid || dec_ready;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      dec_valid <= 1'b1;
    end else if (dec_ready) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      dec_word <= {op, rs1_form, vd, vs1, vs2, sew, mem_sew, vm, imm5};
    end
  end

endmodule

//--- source/vec_ctrl_pkg.sv
`include "vcu_macros.svh"

package vec_ctrl_pkg;

  typedef enum logic [5:0] {
    OP_VADD, OP_VSUB, OP_VRSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR, OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
    OP_VMUL, OP_VMULH, OP_VMULHU, OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM,
    OP_VWADDU, OP_VWADD, OP_VWSUBU, OP_VWSUB,
    OP_VMAND, OP_VMOR, OP_VMXOR,
    OP_VLE, OP_VLSE, OP_VSE, OP_VSSE,
    BAD_OP
  } vop_t;

  // matches the vsew encoding of vtype
  typedef enum logic [1:0] {
    SEW8  = 2'b00,
    SEW16 = 2'b01,
    SEW32 = 2'b10
  } sew_t;

  typedef enum logic [2:0] {
    ARITH, RED, MUL, DIV, MASK, LOAD_UNIT, STORE_UNIT
  } fu_type_t;

  typedef enum logic [2:0] {
    VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR, VALU_COMP, VALU_MM, VALU_SHIFT
  } valu_op_t;

  typedef enum logic {
    UNSIGNED = 1'b0,
    SIGNED   = 1'b1
  } signedness_t;

  // first operand source: vector, scalar or immediate
  typedef enum logic [1:0] {
    V = 2'b00,
    X = 2'b01,
    I = 2'b10
  } rs1_type_t;

  typedef logic [`VCU_DEC_W-1:0] dec_word_t;

endpackage

//--- source/vec_isa_pkg.sv
`include "vcu_macros.svh"

package vec_isa_pkg;

  typedef logic [`VCU_INSTR_W-1:0] instr_t;
  typedef logic [`VCU_VREG_W-1:0]  vreg_idx_t;

  typedef enum logic [6:0] {
    LOAD_FP  = 7'b0000111,
    STORE_FP = 7'b0100111,
    VECTOR   = 7'b1010111
  } opcode_t;

  // operand form, funct3 of the vector opcode
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_t;

  typedef enum logic [5:0] {
    VADD   = 6'b000000,
    VSUB   = 6'b000010,
    VRSUB  = 6'b000011,
    VMINU  = 6'b000100,
    VMIN   = 6'b000101,
    VMAXU  = 6'b000110,
    VMAX   = 6'b000111,
    VAND   = 6'b001001,
    VOR    = 6'b001010,
    VXOR   = 6'b001011,
    VMSEQ  = 6'b011000,
    VMSNE  = 6'b011001,
    VMSLTU = 6'b011010,
    VMSLT  = 6'b011011,
    VSLL   = 6'b100101,
    VSRL   = 6'b101000,
    VSRA   = 6'b101001
  } vopi_t;

  typedef enum logic [5:0] {
    VREDSUM = 6'b000000,
    VREDAND = 6'b000001,
    VREDOR  = 6'b000010,
    VREDXOR = 6'b000011,
    VMAND   = 6'b011001,
    VMOR    = 6'b011010,
    VMXOR   = 6'b011011,
    VDIVU   = 6'b100000,
    VDIV    = 6'b100001,
    VREMU   = 6'b100010,
    VREM    = 6'b100011,
    VMULHU  = 6'b100100,
    VMUL    = 6'b100101,
    VMULH   = 6'b100111,
    VWADDU  = 6'b110000,
    VWADD   = 6'b110001,
    VWSUBU  = 6'b110010,
    VWSUB   = 6'b110011
  } vopm_t;

  // indexed modes 01 and 11 are not supported
  typedef enum logic [1:0] {
    MOP_UNIT    = 2'b00,
    MOP_STRIDED = 2'b10
  } mop_t;

  typedef enum logic [2:0] {
    WIDTH8  = 3'b000,
    WIDTH16 = 3'b101,
    WIDTH32 = 3'b110
  } width_t;

endpackage

//--- source/vcu_macros.svh
`ifndef VCU_MACROS_SVH
`define VCU_MACROS_SVH

`define VCU_INSTR_W     32
`define VCU_VREG_W      5
`define VCU_QUEUE_DEPTH 4

// op(6) + rs1 form(2) + vd/vs1/vs2(15) + sew/mem sew(4) + vm(1) + imm(5)
`define VCU_DEC_W       33

`endif
